/* Makefile */
TOP = tbWbStats

all: run

obj_dir/V$(TOP): flist.f $(wildcard hdl/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* flist.f */
hdl/wbPkg.sv
hdl/wbMaster.sv
hdl/wbMemSlave.sv
hdl/wbStatsMonitor.sv
hdl/wbStatsSubsystem.sv
verif/wbStatsAsserts_asserts.sv
verif/tbWbStats.sv

/* hdl/wbMaster.sv */
`timescale 1ns/1ps

module wbMaster
	import wbPkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   cmdValid,
	input  logic   cmdWe,
	input  wbAddrT cmdAddr,
	input  wbDataT cmdData,
	input  logic   ack,
	input  logic   err,
	input  wbDataT datR,
	output logic   busy,
	output logic   cyc,
	output logic   stb,
	output logic   we,
	output wbAddrT adr,
	output wbDataT datW,
	output logic   rspValid,
	output logic   rspErr,
	output wbDataT rspData
);

	masterStateT state;
	masterStateT nextState;
	logic        cmdAccept;
	logic        busDone;

	// A command is taken whenever no bus cycle is open
	assign cmdAccept = cmdValid && (state != busS);

	// Slave answered, close the cycle
	assign busDone = (state == busS) && (ack || err);

	always_comb
	begin
		nextState = state;
		case (state)
			idleS:
			begin
				if (cmdAccept)
					nextState = busS;
			end
			busS:
			begin
				if (busDone)
					nextState = respondS;
			end
			respondS:
			begin
				if (cmdAccept)
					nextState = busS;
				else
					nextState = idleS;
			end
			default:
			begin
				nextState = idleS;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= idleS;
		else
			state <= nextState;
	end

	// Command latch, held for the whole bus cycle
	always_ff @(posedge clk)
	begin
		if (cmdAccept)
		begin
			we <= cmdWe;
			adr <= cmdAddr;
			datW <= cmdData;
		end
	end

	// Read data only survives a good read
	always_ff @(posedge clk)
	begin
		if (busDone)
		begin
			rspErr <= err;
			if (ack && !we)
				rspData <= datR;
			else
				rspData <= '0;
		end
	end

	assign busy = (state == busS);
	assign cyc = (state == busS);
	assign stb = (state == busS);

	// One-cycle response strobe, bus already released
	assign rspValid = (state == respondS);

endmodule

/* hdl/wbMemSlave.sv */
`timescale 1ns/1ps

module wbMemSlave
	import wbPkg::*;
#(
	parameter int memDepth = 64,
	parameter int waitStates = 1
)
(
	input  logic   clk,
	input  logic   reset,
	input  logic   cyc,
	input  logic   stb,
	input  logic   we,
	input  wbAddrT adr,
	input  wbDataT datW,
	output logic   ack,
	output logic   err,
	output wbDataT datR
);

	localparam int idxWidth = (memDepth > 1) ? $clog2(memDepth) : 1;
	localparam int waitWidth = (waitStates > 0) ? $clog2(waitStates + 1) : 1;

	wbDataT               mem [memDepth];
	logic [waitWidth-1:0] waitCnt;
	logic [idxWidth-1:0]  memIdx;
	logic                 pending;
	logic                 answerNow;
	logic                 inRange;

	// Strobe seen and not yet answered
	assign pending = cyc && stb && !ack && !err;

	// Last wait state reached, answer appears next cycle
	assign answerNow = pending && (waitCnt == waitWidth'(waitStates));

	assign inRange = (32'(adr) < memDepth);
	assign memIdx = adr[idxWidth-1:0];

	always_ff @(posedge clk)
	begin
		if (reset)
			waitCnt <= '0;
		else if (answerNow || !pending)
			waitCnt <= '0;
		else
			waitCnt <= waitCnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			err <= 1'b0;
		end
		else
		begin
			ack <= answerNow && inRange;
			err <= answerNow && !inRange;
		end
	end

	// Cleared on reset so that first reads return zero
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < memDepth; i++)
				mem[i] <= '0;
		end
		else if (answerNow && inRange && we)
		begin
			mem[memIdx] <= datW;
		end
	end

	// Out of range or write cycles return zero
	always_ff @(posedge clk)
	begin
		if (answerNow)
		begin
			if (inRange && !we)
				datR <= mem[memIdx];
			else
				datR <= '0;
		end
	end

endmodule

/* hdl/wbPkg.sv */
package wbPkg;

	// Bus and counter widths
	localparam int addrWidth = 8;
	localparam int dataWidth = 32;
	localparam int countWidth = 16;

	typedef logic [addrWidth-1:0] wbAddrT;
	typedef logic [dataWidth-1:0] wbDataT;
	typedef logic [countWidth-1:0] statCountT;

	typedef enum logic [1:0] {
		idleS,
		busS,
		respondS
	} masterStateT;

	// Window counting, then two report cycles
	typedef enum logic [1:0] {
		countS,
		reportReadS,
		reportWriteS
	} monStateT;

endpackage

/* hdl/wbStatsMonitor.sv */
`timescale 1ns/1ps

module wbStatsMonitor
	import wbPkg::*;
#(
	parameter int windowCycles = 200
)
(
	input  logic      clk,
	input  logic      reset,
	input  logic      cyc,
	input  logic      we,
	input  logic      ack,
	input  logic      err,
	output logic      statValid,
	output logic      statIsWrite,
	output statCountT statCount
);

	localparam int windowWidth = (windowCycles > 1) ? $clog2(windowCycles) : 1;
	localparam logic [windowWidth-1:0] windowLoad = windowWidth'(windowCycles - 1);

	monStateT               state;
	monStateT               nextState;
	logic [windowWidth-1:0] windowCnt;
	logic                   windowEnd;
	logic                   readDone;
	logic                   writeDone;
	statCountT              readCnt;
	statCountT              writeCnt;
	statCountT              readNext;
	statCountT              writeNext;
	statCountT              readSnap;
	statCountT              writeSnap;

	// Saturating increment
	function automatic statCountT satInc(input statCountT value, input logic hit);
		if (hit && (value != '1))
			return value + 1'b1;
		else
			return value;
	endfunction

	// A cycle closed by err is never a completed transfer
	assign readDone = cyc && ack && !err && !we;
	assign writeDone = cyc && ack && !err && we;

	assign readNext = satInc(readCnt, readDone);
	assign writeNext = satInc(writeCnt, writeDone);

	assign windowEnd = (state == countS) && (windowCnt == '0);

	always_comb
	begin
		nextState = state;
		case (state)
			countS:
			begin
				if (windowEnd)
					nextState = reportReadS;
			end
			reportReadS:
			begin
				nextState = reportWriteS;
			end
			reportWriteS:
			begin
				nextState = countS;
			end
			default:
			begin
				nextState = countS;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= countS;
		else
			state <= nextState;
	end

	// Window clock holds during the two report cycles
	always_ff @(posedge clk)
	begin
		if (reset)
			windowCnt <= windowLoad;
		else if (state == reportWriteS)
			windowCnt <= windowLoad;
		else if ((state == countS) && !windowEnd)
			windowCnt <= windowCnt - 1'b1;
	end

	// Counters keep running in report cycles, those go to the new window
	always_ff @(posedge clk)
	begin
		if (reset || windowEnd)
		begin
			readCnt <= '0;
			writeCnt <= '0;
		end
		else
		begin
			readCnt <= readNext;
			writeCnt <= writeNext;
		end
	end

	// Snapshot includes a completion in the last window cycle
	always_ff @(posedge clk)
	begin
		if (windowEnd)
		begin
			readSnap <= readNext;
			writeSnap <= writeNext;
		end
	end

	assign statValid = (state != countS);
	assign statIsWrite = (state == reportWriteS);
	assign statCount = (state == reportWriteS) ? writeSnap : readSnap;

endmodule

/* hdl/wbStatsSubsystem.sv */
`timescale 1ns/1ps

module wbStatsSubsystem
	import wbPkg::*;
#(
	parameter int memDepth = 64,
	parameter int waitStates = 1,
	parameter int windowCycles = 200
)
(
	input  logic      clk,
	input  logic      reset,
	input  logic      cmdValid,
	input  logic      cmdWe,
	input  wbAddrT    cmdAddr,
	input  wbDataT    cmdData,
	output logic      busy,
	output logic      rspValid,
	output logic      rspErr,
	output wbDataT    rspData,
	output logic      statValid,
	output logic      statIsWrite,
	output statCountT statCount
);

	// Internal bus
	logic   cyc;
	logic   stb;
	logic   we;
	wbAddrT adr;
	wbDataT datW;
	logic   ack;
	logic   err;
	wbDataT datR;

	wbMaster u_master (
		.clk      (clk),
		.reset    (reset),
		.cmdValid (cmdValid),
		.cmdWe    (cmdWe),
		.cmdAddr  (cmdAddr),
		.cmdData  (cmdData),
		.ack      (ack),
		.err      (err),
		.datR     (datR),
		.busy     (busy),
		.cyc      (cyc),
		.stb      (stb),
		.we       (we),
		.adr      (adr),
		.datW     (datW),
		.rspValid (rspValid),
		.rspErr   (rspErr),
		.rspData  (rspData)
	);

	wbMemSlave #(
		.memDepth   (memDepth),
		.waitStates (waitStates)
	) u_memSlave (
		.clk   (clk),
		.reset (reset),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.datW  (datW),
		.ack   (ack),
		.err   (err),
		.datR  (datR)
	);

	// Passive, listens to the bus only
	wbStatsMonitor #(
		.windowCycles (windowCycles)
	) u_statsMonitor (
		.clk         (clk),
		.reset       (reset),
		.cyc         (cyc),
		.we          (we),
		.ack         (ack),
		.err         (err),
		.statValid   (statValid),
		.statIsWrite (statIsWrite),
		.statCount   (statCount)
	);

endmodule

/* verif/tbWbStats.sv */
`timescale 1ns/1ps

module tbWbStats
	import wbPkg::*;
();

	localparam int memDepth = 64;
	localparam int waitStates = 1;
	localparam int windowCycles = 200;
	localparam int maxWindows = 64;
	localparam int cmdTimeout = 50;
	localparam int reportTimeout = 2 * (windowCycles + 2) + 20;

	logic      clk;
	logic      reset;
	logic      cmdValid;
	logic      cmdWe;
	wbAddrT    cmdAddr;
	wbDataT    cmdData;
	logic      busy;
	logic      rspValid;
	logic      rspErr;
	wbDataT    rspData;
	logic      statValid;
	logic      statIsWrite;
	statCountT statCount;

	integer    seed;
	int        cycleCount;
	wbDataT    modelMem [memDepth];
	int        modelReads [maxWindows];
	int        modelWrites [maxWindows];
	int        reportsDone;
	statCountT lastReadCount;
	statCountT lastWriteCount;
	int        errorCount;
	int        timeoutCount;
	int        checkTotal;
	int        testNum;
	int        testFails;
	int        testErrStart;
	logic      timedOut;

	wbStatsSubsystem #(
		.memDepth     (memDepth),
		.waitStates   (waitStates),
		.windowCycles (windowCycles)
	) u_wbStatsSubsystem (
		.clk         (clk),
		.reset       (reset),
		.cmdValid    (cmdValid),
		.cmdWe       (cmdWe),
		.cmdAddr     (cmdAddr),
		.cmdData     (cmdData),
		.busy        (busy),
		.rspValid    (rspValid),
		.rspErr      (rspErr),
		.rspData     (rspData),
		.statValid   (statValid),
		.statIsWrite (statIsWrite),
		.statCount   (statCount)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// Cycle 0 is the first cycle with reset low
	always @(posedge clk)
	begin
		if (reset)
			cycleCount <= 0;
		else
			cycleCount <= cycleCount + 1;
	end

	task automatic checkData(input string name, input wbDataT got, input wbDataT exp);
		checkTotal++;
		if (got !== exp)
		begin
			errorCount++;
			$display("FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkErr(input logic got, input logic exp);
		checkTotal++;
		if (got !== exp)
		begin
			errorCount++;
			$display("FAILED rspErr: got 0x%h expected 0x%h at %0t", got, exp, $time);
		end
	endtask

	task automatic checkCount(input string name, input statCountT got, input statCountT exp);
		checkTotal++;
		if (got !== exp)
		begin
			errorCount++;
			$display("FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		checkTotal++;
		if (got !== exp)
		begin
			errorCount++;
			$display("FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkCycles(input string name, input int got, input int exp);
		checkTotal++;
		if (got != exp)
		begin
			errorCount++;
			$display("FAILED %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic noteTimeout(input string what);
		timeoutCount++;
		timedOut = 1'b1;
		$display("TIMEOUT: %s at %0t", what, $time);
	endtask

	// Report cycles after a window of W cycles already belong to the next one
	function automatic int windowOf(input int ackCycle);
		return (ackCycle + 2) / (windowCycles + 2);
	endfunction

	function automatic statCountT satCount(input int n);
		return (n > 65535) ? '1 : statCountT'(n);
	endfunction

	function automatic logic randBit();
		int r;
		r = $random(seed);
		return r[0];
	endfunction

	function automatic wbDataT randData();
		return wbDataT'($random(seed));
	endfunction

	function automatic wbAddrT randInRange();
		int r;
		r = $random(seed);
		return wbAddrT'($unsigned(r) % memDepth);
	endfunction

	function automatic wbAddrT randOutRange();
		int r;
		r = $random(seed);
		return wbAddrT'(memDepth + $unsigned(r) % (256 - memDepth));
	endfunction

	function automatic wbAddrT randAddrMixed();
		int r;
		r = $random(seed);
		return (r[1:0] == 2'b00) ? randOutRange() : randInRange();
	endfunction

	// Issues one command and checks latency, response and model contents
	task automatic doCommand(input logic isWrite, input wbAddrT addr, input wbDataT data);
		int n;
		int idx;
		int w;
		logic inRange;
		wbDataT expData;
		if (timedOut)
			return;
		@(negedge clk);
		n = 0;
		while (busy && n < cmdTimeout)
		begin
			@(negedge clk);
			n++;
		end
		if (busy)
		begin
			noteTimeout("busy stayed high, command could not be issued");
			return;
		end
		cmdValid = 1'b1;
		cmdWe = isWrite;
		cmdAddr = addr;
		cmdData = data;
		@(negedge clk);
		cmdValid = 1'b0;
		n = 1;
		while (!rspValid && n < cmdTimeout)
		begin
			checkFlag("busy", busy, 1'b1);
			@(negedge clk);
			n++;
		end
		if (!rspValid)
		begin
			noteTimeout("no response strobe after a command");
			return;
		end
		checkCycles("rspValid latency", n, waitStates + 3);
		checkFlag("busy", busy, 1'b0);
		idx = int'(addr);
		inRange = (idx < memDepth);
		expData = (!isWrite && inRange) ? modelMem[idx] : '0;
		checkErr(rspErr, !inRange);
		checkData("rspData", rspData, expData);
		if (inRange && isWrite)
			modelMem[idx] = data;
		// Ack was the cycle before the response
		w = windowOf(cycleCount - 1);
		if (inRange && w < maxWindows)
		begin
			if (isWrite)
				modelWrites[w]++;
			else
				modelReads[w]++;
		end
	endtask

	task automatic waitReports(input int target);
		int n;
		n = 0;
		while (reportsDone < target && n < reportTimeout && !timedOut)
		begin
			@(negedge clk);
			n++;
		end
		if (reportsDone < target)
			noteTimeout("statistics reports did not arrive");
	endtask

	// Background checker for report order, period and counts
	initial
	begin
		int n;
		int w;
		int reportCycle;
		statCountT readSeen;
		n = 0;
		@(negedge clk);
		while (reset && n < 100)
		begin
			@(negedge clk);
			n++;
		end
		w = 0;
		while (!timedOut && w < maxWindows)
		begin
			reportCycle = w * (windowCycles + 2) + windowCycles;
			n = 0;
			@(negedge clk);
			while (!statValid && n < windowCycles + 10)
			begin
				@(negedge clk);
				n++;
			end
			if (!statValid)
				noteTimeout("no statistics report within a window");
			else
			begin
				checkFlag("statIsWrite", statIsWrite, 1'b0);
				checkCycles("read report cycle", cycleCount, reportCycle);
				readSeen = statCount;
				@(negedge clk);
				checkFlag("statValid", statValid, 1'b1);
				checkFlag("statIsWrite", statIsWrite, 1'b1);
				checkCount("statCount read", readSeen, satCount(modelReads[w]));
				checkCount("statCount write", statCount, satCount(modelWrites[w]));
				lastReadCount = readSeen;
				lastWriteCount = statCount;
				w++;
				reportsDone = w;
			end
		end
	end

	task automatic testResetState();
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clk);
			checkFlag("busy", busy, 1'b0);
			checkFlag("rspValid", rspValid, 1'b0);
			checkFlag("statValid", statValid, 1'b0);
		end
		for (int i = 0; i < 8; i++)
			doCommand(1'b0, randInRange(), '0);
	endtask

	task automatic testWriteReadBack();
		wbAddrT addrList[$];
		wbAddrT addr;
		for (int i = 0; i < 24; i++)
		begin
			addr = randInRange();
			addrList.push_back(addr);
			doCommand(1'b1, addr, randData());
		end
		foreach (addrList[i])
			doCommand(1'b0, addrList[i], '0);
		for (int i = 0; i < 8; i++)
			doCommand(1'b0, randInRange(), '0);
	endtask

	// Aliased in-range read shows memory untouched
	task automatic testOutOfRange();
		wbAddrT addr;
		for (int i = 0; i < 12; i++)
		begin
			addr = randOutRange();
			doCommand(randBit(), addr, randData());
			doCommand(1'b0, wbAddrT'(int'(addr) % memDepth), '0);
		end
	endtask

	task automatic testLatency();
		for (int i = 0; i < 16; i++)
			doCommand(randBit(), randAddrMixed(), randData());
	endtask

	task automatic testWindowStats();
		int stopCycle;
		int idle;
		stopCycle = cycleCount + 3 * (windowCycles + 2);
		while (cycleCount < stopCycle && !timedOut)
		begin
			doCommand(randBit(), randAddrMixed(), randData());
			idle = $unsigned($random(seed)) % 4;
			repeat (idle) @(negedge clk);
		end
		waitReports(windowOf(cycleCount) + 1);
	endtask

	task automatic testIdleWindow();
		repeat (3) @(negedge clk);
		waitReports(reportsDone + 1);
		waitReports(reportsDone + 1);
		checkCount("idle statCount read", lastReadCount, '0);
		checkCount("idle statCount write", lastWriteCount, '0);
	endtask

	task automatic finishTest(input string name);
		int errs;
		errs = errorCount + timeoutCount - testErrStart;
		testNum++;
		if (errs == 0)
			$display("test %0d %s: passed", testNum, name);
		else
		begin
			testFails++;
			$display("test %0d %s: failed with %0d errors", testNum, name, errs);
		end
		testErrStart = errorCount + timeoutCount;
	endtask

	initial
	begin
		seed = 1;
		reset = 1'b1;
		cmdValid = 1'b0;
		cmdWe = 1'b0;
		cmdAddr = '0;
		cmdData = '0;
		timedOut = 1'b0;
		reportsDone = 0;
		lastReadCount = '0;
		lastWriteCount = '0;
		errorCount = 0;
		timeoutCount = 0;
		checkTotal = 0;
		testNum = 0;
		testFails = 0;
		testErrStart = 0;
		for (int i = 0; i < memDepth; i++)
			modelMem[i] = '0;
		for (int i = 0; i < maxWindows; i++)
		begin
			modelReads[i] = 0;
			modelWrites[i] = 0;
		end
		repeat (8) @(negedge clk);
		reset = 1'b0;

		testResetState();
		finishTest("reset state");
		testWriteReadBack();
		finishTest("write then read-back");
		testOutOfRange();
		finishTest("out-of-range access");
		testLatency();
		finishTest("response latency");
		testWindowStats();
		finishTest("window statistics");
		testIdleWindow();
		finishTest("idle window");

		$display("tests %0d, failed %0d, checks %0d, errors %0d, timeouts %0d",
			testNum, testFails, checkTotal, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0 && testFails == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* verif/wbStatsAsserts_asserts.sv */
`timescale 1ns/1ps

module wbStatsAsserts (
	input logic clk,
	input logic reset,
	input logic cmdValid,
	input logic busy,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic err
);

	ackErrExclusive: assert property (@(posedge clk) disable iff (reset)
		!(ack && err))
		else $error("ack and err high together");

	answerNeedsStb: assert property (@(posedge clk) disable iff (reset)
		(ack || err) |-> stb)
		else $error("ack or err without stb");

	// Bus cycle open until the slave answers
	cycHeld: assert property (@(posedge clk) disable iff (reset)
		(cyc && !ack && !err) |=> cyc)
		else $error("cyc dropped before ack or err");

	cycReleased: assert property (@(posedge clk) disable iff (reset)
		(ack || err) |=> !cyc)
		else $error("cyc still high after ack or err");

	noCmdWhileBusy: assert property (@(posedge clk) disable iff (reset)
		!(cmdValid && busy))
		else $error("cmdValid raised while busy");

endmodule

bind wbStatsSubsystem wbStatsAsserts u_wbStatsAsserts (
	.clk      (clk),
	.reset    (reset),
	.cmdValid (cmdValid),
	.busy     (busy),
	.cyc      (cyc),
	.stb      (stb),
	.ack      (ack),
	.err      (err)
);
